//--- merge_macros.svh
`ifndef MERGE_MACROS_SVH
`define MERGE_MACROS_SVH

// Width of one data word, for the bank, the merged words and the results.
`define MERGE_DATA_W 32

// Width of the start delay and of the stride fields.
`define MERGE_DELAY_W 7

// Words in one bank.
// Kept at 16 so the 4-bit selection counter wraps through the whole bank.
`define MERGE_N_IN 16

`endif

//--- merge_pkg.sv
`include "merge_macros.svh"

package merge_pkg;

   // One bank of input words, all presented in the same cycle.
   typedef struct packed {
      logic [`MERGE_DATA_W-1:0] word0;
      logic [`MERGE_DATA_W-1:0] word1;
      logic [`MERGE_DATA_W-1:0] word2;
      logic [`MERGE_DATA_W-1:0] word3;
      logic [`MERGE_DATA_W-1:0] word4;
      logic [`MERGE_DATA_W-1:0] word5;
      logic [`MERGE_DATA_W-1:0] word6;
      logic [`MERGE_DATA_W-1:0] word7;
      logic [`MERGE_DATA_W-1:0] word8;
      logic [`MERGE_DATA_W-1:0] word9;
      logic [`MERGE_DATA_W-1:0] word10;
      logic [`MERGE_DATA_W-1:0] word11;
      logic [`MERGE_DATA_W-1:0] word12;
      logic [`MERGE_DATA_W-1:0] word13;
      logic [`MERGE_DATA_W-1:0] word14;
      logic [`MERGE_DATA_W-1:0] word15;
   } merge_bank_t;

   // Setting of one merge unit.
   typedef struct packed {
      logic [`MERGE_DELAY_W-1:0] delay0; // Cycles before the first advance.
      logic [`MERGE_DELAY_W-1:0] stride; // Extra cycles each word is held.
   } merge_cfg_t;

   // Operation applied to the two merged words.
   typedef enum logic [1:0] {
      op_add = 2'd0,
      op_sub = 2'd1,
      op_max = 2'd2, // Unsigned.
      op_min = 2'd3  // Unsigned.
   } combine_op_t;

   typedef struct packed {
      logic [`MERGE_DATA_W-1:0] value; // Last combined word.
      logic [`MERGE_DATA_W-1:0] acc;   // Running sum of combined words, wraps.
   } merge_result_t;

endpackage

//--- strided_merge.sv
`timescale 1ns/1ps
`include "merge_macros.svh"

module strided_merge (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     run,
   input  logic                     running,
   input  merge_pkg::merge_bank_t   bank,
   input  merge_pkg::merge_cfg_t    cfg,
   output logic [`MERGE_DATA_W-1:0] word,
   output logic                     running_q
);

   import merge_pkg::*;

   localparam int SEL_W = $clog2(`MERGE_N_IN);

   logic [`MERGE_DELAY_W-1:0] delay; // Start delay still to run.
   logic [`MERGE_DELAY_W-1:0] hold;  // Cycles left on the current word.
   logic [SEL_W-1:0]          counter;
   logic [`MERGE_DATA_W-1:0]  selected;

   // Sixteen-way selection of one bank word.
   function automatic logic [`MERGE_DATA_W-1:0] pick_word(
      input merge_bank_t      b,
      input logic [SEL_W-1:0] idx
   );
      logic [`MERGE_DATA_W-1:0] w;
      case (idx)
         0:  w = b.word0;
         1:  w = b.word1;
         2:  w = b.word2;
         3:  w = b.word3;
         4:  w = b.word4;
         5:  w = b.word5;
         6:  w = b.word6;
         7:  w = b.word7;
         8:  w = b.word8;
         9:  w = b.word9;
         10: w = b.word10;
         11: w = b.word11;
         12: w = b.word12;
         13: w = b.word13;
         14: w = b.word14;
         default: w = b.word15;
      endcase
      return w;
   endfunction

   always_comb begin
      selected = pick_word(bank, counter); // Uses the counter before its update.
   end

   // Delay, hold and selection counter.
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         delay   <= '0;
         hold    <= '0;
         counter <= '0;
      end else if (run) begin
         delay   <= cfg.delay0;
         hold    <= cfg.stride;
         counter <= '0;
      end else if (running) begin
         if (delay != '0) begin
            delay <= delay - 1'b1;
            // Last delay cycle, so the first word gets a full hold.
            if (delay == 1) begin
               hold <= cfg.stride;
            end
         end else if (hold == '0) begin
            counter <= counter + 1'b1; // Wraps at the end of the bank.
            hold    <= cfg.stride;
         end else begin
            hold <= hold - 1'b1;
         end
      end
   end

   // The picked word is registered on every running cycle that is not a start.
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         word <= '0;
      end else if (running && !run) begin
         word <= selected;
      end
   end

   // Marks for the combiner that word was just refreshed.
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         running_q <= 1'b0;
      end else begin
         running_q <= running;
      end
   end

endmodule

//--- merge_combiner.sv
`timescale 1ns/1ps
`include "merge_macros.svh"

module merge_combiner (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     run,
   input  logic                     running_q,
   input  logic [`MERGE_DATA_W-1:0] word_a,
   input  logic [`MERGE_DATA_W-1:0] word_b,
   input  merge_pkg::combine_op_t   op,
   output merge_pkg::merge_result_t result
);

   import merge_pkg::*;

   logic [`MERGE_DATA_W-1:0] combined;
   logic [`MERGE_DATA_W-1:0] acc_next;

   // All arithmetic wraps at the data width.
   function automatic logic [`MERGE_DATA_W-1:0] apply_op(
      input combine_op_t              sel,
      input logic [`MERGE_DATA_W-1:0] a,
      input logic [`MERGE_DATA_W-1:0] b
   );
      logic [`MERGE_DATA_W-1:0] r;
      case (sel)
         op_add:  r = a + b;
         op_sub:  r = a - b;
         op_max:  r = (a >= b) ? a : b;
         op_min:  r = (a <= b) ? a : b;
         default: r = a;
      endcase
      return r;
   endfunction

   always_comb begin
      combined = apply_op(op, word_a, word_b);
      acc_next = result.acc + combined; // The sum includes the value registered now.
   end

   // Combined word, taken whenever the merge units hand over fresh words.
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         result.value <= '0;
      end else if (running_q) begin
         result.value <= combined;
      end
   end

   // A start clears the sum so that each pass accumulates from zero.
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         result.acc <= '0;
      end else if (run) begin
         result.acc <= '0;
      end else if (running_q) begin
         result.acc <= acc_next;
      end
   end

endmodule

//--- dual_merge_top.sv
`timescale 1ns/1ps
`include "merge_macros.svh"

module dual_merge_top (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     run,
   input  logic                     running,
   input  merge_pkg::merge_bank_t   bank,
   input  merge_pkg::merge_cfg_t    cfg_a,
   input  merge_pkg::merge_cfg_t    cfg_b,
   input  merge_pkg::combine_op_t   op,
   output merge_pkg::merge_result_t result
);

   logic [`MERGE_DATA_W-1:0] word_a;
   logic [`MERGE_DATA_W-1:0] word_b;
   logic                     running_q; // From unit a; both units carry the same copy.

   // Both units walk the same bank, each on its own delay and stride.
   strided_merge u_merge_a (
      .clk       (clk),
      .rst       (rst),
      .run       (run),
      .running   (running),
      .bank      (bank),
      .cfg       (cfg_a),
      .word      (word_a),
      .running_q (running_q)
   );

   strided_merge u_merge_b (
      .clk       (clk),
      .rst       (rst),
      .run       (run),
      .running   (running),
      .bank      (bank),
      .cfg       (cfg_b),
      .word      (word_b),
      .running_q ()
   );

   // Result lags the sampled bank by two cycles.
   merge_combiner u_combiner (
      .clk       (clk),
      .rst       (rst),
      .run       (run),
      .running_q (running_q),
      .word_a    (word_a),
      .word_b    (word_b),
      .op        (op),
      .result    (result)
   );

endmodule

//--- tb_merge_model.svh
`ifndef TB_MERGE_MODEL_SVH
`define TB_MERGE_MODEL_SVH

// Reference state of both merge units and of the combiner. Index 0 is unit a.
// The picked words form the first stage and value and acc the second.
logic [`MERGE_DELAY_W-1:0] m_delay [2];
logic [`MERGE_DELAY_W-1:0] m_hold [2];
logic [3:0]                m_ctr [2];
logic [3:0]                m_pick [2]; // Counter value behind m_word.
logic [`MERGE_DATA_W-1:0]  m_word [2];
logic                      m_running_q;
logic [`MERGE_DATA_W-1:0]  m_value;
logic [`MERGE_DATA_W-1:0]  m_acc;

function automatic logic [`MERGE_DATA_W-1:0] bank_word(
   input merge_bank_t b,
   input logic [3:0]  idx
);
   logic [`MERGE_DATA_W*`MERGE_N_IN-1:0] flat;
   int                                   pos;
   flat = b;
   pos = (`MERGE_N_IN - 1 - int'(idx)) * `MERGE_DATA_W; // Word 0 sits in the top bits.
   return flat[pos +: `MERGE_DATA_W];
endfunction

function automatic logic [`MERGE_DATA_W-1:0] model_op(
   input combine_op_t              o,
   input logic [`MERGE_DATA_W-1:0] a,
   input logic [`MERGE_DATA_W-1:0] b
);
   logic [`MERGE_DATA_W-1:0] r;
   if (o == op_add) begin
      r = a + b;
   end else if (o == op_sub) begin
      r = a - b;
   end else if (o == op_max) begin
      r = (a > b) ? a : b;
   end else begin
      r = (a < b) ? a : b;
   end
   return r;
endfunction

task automatic model_reset();
   for (int u = 0; u < 2; u++) begin
      m_delay[u] = '0;
      m_hold[u]  = '0;
      m_ctr[u]   = '0;
      m_pick[u]  = '0;
      m_word[u]  = '0;
   end
   m_running_q = 1'b0;
   m_value     = '0;
   m_acc       = '0;
endtask

// One unit across one rising edge, with the inputs that the edge samples.
task automatic unit_step(input int u, input merge_cfg_t c);
   if (run) begin
      m_delay[u] = c.delay0;
      m_hold[u]  = c.stride;
      m_ctr[u]   = '0;
   end else if (running) begin
      m_word[u] = bank_word(bank, m_ctr[u]); // Picked before the counter moves.
      m_pick[u] = m_ctr[u];
      if (m_delay[u] != '0) begin
         if (m_delay[u] == 1) begin
            m_hold[u] = c.stride;
         end
         m_delay[u] = m_delay[u] - 1'b1;
      end else if (m_hold[u] == '0) begin
         m_ctr[u]  = m_ctr[u] + 1'b1;
         m_hold[u] = c.stride;
      end else begin
         m_hold[u] = m_hold[u] - 1'b1;
      end
   end
endtask

task automatic model_step();
   logic [`MERGE_DATA_W-1:0] combined;
   combined = model_op(op, m_word[0], m_word[1]); // Words of the previous edge.
   if (m_running_q) begin
      m_value = combined;
   end
   if (run) begin
      m_acc = '0;
   end else if (m_running_q) begin
      m_acc = m_acc + combined;
   end
   unit_step(0, cfg_a);
   unit_step(1, cfg_b);
   m_running_q = running;
endtask

`endif

//--- tb_dual_merge.sv
`timescale 1ns/1ps
`include "merge_macros.svh"

module tb_dual_merge;

   import merge_pkg::*;

   localparam int RESET_CYCLES    = 4;
   localparam int WATCHDOG_CYCLES = 20000;
   localparam int N_PASSES        = 10;

   localparam logic [`MERGE_DATA_W-1:0] WRAP_A  = 32'h0000_0010;
   localparam logic [`MERGE_DATA_W-1:0] WRAP_B  = 32'hFFFF_FFF8;
   localparam logic [`MERGE_DATA_W-1:0] EQUAL_W = 32'h8000_0003;

   // Add, sub, max and min of WRAP_A with WRAP_B, in the order of the op codes.
   localparam logic [`MERGE_DATA_W-1:0] WRAP_RES [4] = '{
      32'h0000_0008, 32'h0000_0018, 32'hFFFF_FFF8, 32'h0000_0010
   };
   // The same four operations with EQUAL_W on both sides.
   localparam logic [`MERGE_DATA_W-1:0] EQUAL_RES [4] = '{
      32'h0000_0006, 32'h0000_0000, 32'h8000_0003, 32'h8000_0003
   };

   logic          clk;
   logic          rst;
   logic          run;
   logic          running;
   merge_bank_t   bank;
   merge_cfg_t    cfg_a;
   merge_cfg_t    cfg_b;
   combine_op_t   op;
   merge_result_t result;

   // Settings applied at the next rising edge.
   merge_cfg_t  next_cfg_a;
   merge_cfg_t  next_cfg_b;
   combine_op_t next_op;

   integer seed = 32'ha126;
   string  test_name;
   logic   index_bank_on; // Word k of the bank holds k, so a word shows its index.

   dual_merge_top UUT (
      .clk     (clk),
      .rst     (rst),
      .run     (run),
      .running (running),
      .bank    (bank),
      .cfg_a   (cfg_a),
      .cfg_b   (cfg_b),
      .op      (op),
      .result  (result)
   );

   `include "tb_merge_model.svh"

   always #20 clk = ~clk;

   task automatic abort_run();
      $display("=== FAIL ===");
      $fatal(1, "Simulation stopped at the first error.");
   endtask

   task automatic check_word(
      input string                    name,
      input logic [`MERGE_DATA_W-1:0] exp,
      input logic [`MERGE_DATA_W-1:0] act
   );
      if (act !== exp) begin
         $display("ERROR %s: expected %h, actual %h", name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_result(input string name, input merge_result_t exp,
                               input merge_result_t act);
      if (act !== exp) begin
         $display("ERROR %s: expected value %h acc %h, actual value %h acc %h",
                  name, exp.value, exp.acc, act.value, act.acc);
         abort_run();
      end
   endtask

   task automatic check_counter(input string name, input logic [3:0] exp,
                                input logic [3:0] act);
      if (act !== exp) begin
         $display("ERROR %s: expected index %0d, actual index %0d", name, exp, act);
         abort_run();
      end
   endtask

   function automatic merge_bank_t index_bank();
      logic [`MERGE_DATA_W*`MERGE_N_IN-1:0] flat;
      for (int k = 0; k < `MERGE_N_IN; k++) begin
         flat[(`MERGE_N_IN-1-k)*`MERGE_DATA_W +: `MERGE_DATA_W] = k;
      end
      return flat;
   endfunction

   // Word 0 gets first and every other word gets rest.
   function automatic merge_bank_t two_word_bank(input logic [`MERGE_DATA_W-1:0] first,
                                                 input logic [`MERGE_DATA_W-1:0] rest);
      logic [`MERGE_DATA_W*`MERGE_N_IN-1:0] flat;
      for (int k = 0; k < `MERGE_N_IN; k++) begin
         flat[(`MERGE_N_IN-1-k)*`MERGE_DATA_W +: `MERGE_DATA_W] = (k == 0) ? first : rest;
      end
      return flat;
   endfunction

   function automatic merge_bank_t random_bank();
      logic [`MERGE_DATA_W*`MERGE_N_IN-1:0] flat;
      for (int k = 0; k < `MERGE_N_IN; k++) begin
         flat[k*`MERGE_DATA_W +: `MERGE_DATA_W] = $random(seed);
      end
      return flat;
   endfunction

   task automatic pick_config(output merge_cfg_t c);
      logic [31:0] r;
      r = $random(seed);
      c = '0;
      c.delay0[3:0] = r[3:0];
      c.stride[3:0] = r[7:4];
   endtask

   task automatic pick_mode();
      logic [31:0] r;
      pick_config(next_cfg_a);
      pick_config(next_cfg_b);
      r = $random(seed);
      next_op = combine_op_t'(r[1:0]);
   endtask

   // One clock cycle. The DUT state left by the last edge is checked and the model
   // then takes the inputs that the next edge samples.
   task automatic drive(input logic r, input logic rn, input merge_bank_t b);
      merge_result_t exp;
      @(posedge clk);
      run     <= r;
      running <= rn;
      bank    <= b;
      cfg_a   <= next_cfg_a;
      cfg_b   <= next_cfg_b;
      op      <= next_op;
      @(negedge clk);
      exp.value = m_value;
      exp.acc   = m_acc;
      check_result(test_name, exp, result);
      check_word({test_name, " word_a"}, m_word[0], UUT.word_a);
      check_word({test_name, " word_b"}, m_word[1], UUT.word_b);
      if (index_bank_on) begin
         check_counter({test_name, " counter a"}, m_pick[0], UUT.word_a[3:0]);
         check_counter({test_name, " counter b"}, m_pick[1], UUT.word_b[3:0]);
      end
      model_step();
   endtask

   task automatic wait_value_nonzero(input int limit);
      int n;
      n = 0;
      while (result.value == '0 && n < limit) begin
         drive(1'b0, 1'b1, index_bank());
         n++;
      end
      if (result.value == '0) begin
         $display("Timeout: result.value stayed zero for %0d running cycles", limit);
         abort_run();
      end
   endtask

   initial begin
      for (int cycles = 0; cycles < WATCHDOG_CYCLES; cycles++) begin
         @(posedge clk);
      end
      $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
      abort_run();
   end

   initial begin
      int               len;
      int               cut;
      logic [31:0]      r;
      merge_result_t    held;
      logic [`MERGE_DATA_W-1:0] held_a;
      merge_bank_t      b;
      combine_op_t      o;
      clk           = 1'b0;
      rst           = 1'b1;
      run           = 1'b0;
      running       = 1'b0;
      bank          = '0;
      cfg_a         = '0;
      cfg_b         = '0;
      op            = op_add;
      next_cfg_a    = '0;
      next_cfg_b    = '0;
      next_op       = op_add;
      index_bank_on = 1'b0;
      test_name     = "after reset";
      model_reset();
      repeat (RESET_CYCLES) @(posedge clk);
      rst <= 1'b0;

      for (int i = 0; i < 3; i++) begin
         drive(1'b0, 1'b0, '0);
      end
      check_word("after reset value", '0, result.value);
      check_word("after reset acc", '0, result.acc);

      // Identical units on an index bank always pick the same word.
      test_name     = "fixed order";
      index_bank_on = 1'b1;
      next_op       = op_sub;
      drive(1'b0, 1'b0, index_bank());
      drive(1'b1, 1'b1, index_bank());
      for (int i = 0; i < 40; i++) begin
         drive(1'b0, 1'b1, index_bank());
         check_word("fixed order value", '0, result.value);
         check_word("fixed order acc", '0, result.acc);
      end

      test_name         = "delayed unit b";
      next_cfg_b.delay0 = 3;
      drive(1'b0, 1'b0, index_bank());
      drive(1'b1, 1'b1, index_bank());
      wait_value_nonzero(20);
      for (int i = 0; i < 30; i++) begin
         drive(1'b0, 1'b1, index_bank());
      end
      drive(1'b0, 1'b0, index_bank());
      index_bank_on = 1'b0;

      for (int p = 0; p < N_PASSES; p++) begin
         test_name = $sformatf("random pass %0d", p);
         pick_mode();
         r   = $random(seed);
         len = 20 + int'($unsigned(r[15:8]) % 61);
         drive(1'b0, 1'b0, random_bank());
         drive(1'b1, 1'b1, random_bank());
         for (int i = 0; i < len; i++) begin
            drive(1'b0, 1'b1, random_bank());
         end
         drive(1'b0, 1'b0, random_bank());
      end

      test_name = "restart";
      pick_mode();
      drive(1'b0, 1'b0, random_bank());
      drive(1'b1, 1'b1, random_bank());
      for (int i = 0; i < 25; i++) begin
         drive(1'b0, 1'b1, random_bank());
      end
      drive(1'b1, 1'b1, random_bank()); // Start again in the middle of the pass.
      drive(1'b0, 1'b1, random_bank());
      check_word("restart acc cleared", '0, result.acc);
      for (int i = 0; i < 30; i++) begin
         drive(1'b0, 1'b1, random_bank());
      end
      drive(1'b0, 1'b0, random_bank());

      // The words freeze one edge into a pause and the result one edge later.
      test_name = "pause";
      pick_mode();
      drive(1'b0, 1'b0, random_bank());
      drive(1'b1, 1'b1, random_bank());
      for (int k = 0; k < 6; k++) begin
         r   = $random(seed);
         len = 5 + int'(r[3:0]);
         cut = 3 + int'(r[6:4]);
         for (int i = 0; i < len; i++) begin
            drive(1'b0, 1'b1, random_bank());
         end
         for (int i = 0; i < cut; i++) begin
            drive(1'b0, 1'b0, random_bank());
            if (i == 0) begin
               held_a = UUT.word_a;
            end else begin
               check_word("pause word_a hold", held_a, UUT.word_a);
            end
            if (i == 1) begin
               held = result;
            end else if (i > 1) begin
               check_result("pause result hold", held, result);
            end
         end
      end

      // Unit b waits at word 0 while unit a moves on to the other words.
      for (int k = 0; k < 4; k++) begin
         o                 = combine_op_t'(k);
         test_name         = $sformatf("%s wrap", o.name());
         next_op           = o;
         next_cfg_a        = '0;
         next_cfg_b        = '0;
         next_cfg_b.delay0 = 100;
         b = two_word_bank(WRAP_B, WRAP_A);
         drive(1'b0, 1'b0, b);
         drive(1'b1, 1'b1, b);
         for (int i = 0; i < 8; i++) begin
            drive(1'b0, 1'b1, b);
         end
         check_word(test_name, WRAP_RES[k], result.value);

         test_name = $sformatf("%s equal", o.name());
         b = two_word_bank(EQUAL_W, EQUAL_W);
         drive(1'b0, 1'b0, b);
         drive(1'b1, 1'b1, b);
         for (int i = 0; i < 4; i++) begin
            drive(1'b0, 1'b1, b);
         end
         check_word(test_name, EQUAL_RES[k], result.value);
         drive(1'b0, 1'b0, b);
      end

      test_name = "end";
      drive(1'b0, 1'b0, '0);
      $display("=== PASS ===");
      $finish;
   end

endmodule

//--- filelist.f
+incdir+.
merge_pkg.sv
strided_merge.sv
merge_combiner.sv
dual_merge_top.sv
tb_dual_merge.sv

//--- Makefile
# Verilator build and run of the dual merge testbench.

VERILATOR  ?= verilator
TOP        ?= tb_dual_merge
RTL_TOP    ?= dual_merge_top
FILELIST   ?= filelist.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall
PASS_MSG   ?= === PASS ===
RTL_SRCS   ?= merge_pkg.sv strided_merge.sv merge_combiner.sv dual_merge_top.sv

HDRS := merge_macros.svh tb_merge_model.svh
SRCS := $(RTL_SRCS) tb_dual_merge.sv $(HDRS) $(FILELIST)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(BIN)

$(BIN): $(SRCS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# The run passes only if the pass message shows up in the simulation output.
run: $(BIN)
	@out="$$(./$(BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -I. $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR)
